/* ssd1306_oled.f */
source/oled_pkg.sv
source/oled_vram.sv
source/oled_i2c_byte.sv
source/oled_sequencer.sv
source/oled_top.sv
sim/oled_sva.sv
sim/oled_tb.sv

/* Bender.yml */
package:
  name: ssd1306_oled

sources:
  - source/oled_pkg.sv
  - source/oled_vram.sv
  - source/oled_i2c_byte.sv
  - source/oled_sequencer.sv
  - source/oled_top.sv
  - target: simulation
    files:
      - sim/oled_sva.sv
      - sim/oled_tb.sv

/* sim/oled_tb.sv */
`timescale 1ns/1ps
// oled controller testbench
// host port checks, an i2c slave that decodes and acks the bytes, and a
// comparison of the init and frame transactions with a reference model
module oled_tb import oled_pkg::*; ();

  localparam int CYC         = 100;
  localparam int BYTE_CYC    = 36;  // 8 data bits and ack at 4 cycles each
  localparam int INIT_TXN    = 27;
  localparam int FRAME_TXN   = VRAM_DEPTH + 2;
  localparam int TIMEOUT_CYC = (INIT_TXN + 3 * FRAME_TXN) * BYTE_CYC * 3 / 2;
  localparam int NACK_TXN    = 3;    // third frame
  localparam int NACK_POS    = 300;  // byte position inside it
  localparam int N_TXN       = 5;

  localparam logic [7:0] INIT_REF [25] = '{
    8'hAE, 8'hA8, 8'h3F, 8'h40, 8'hA0, 8'hC0, 8'hDA, 8'h12, 8'h81, 8'h7F,
    8'hA4, 8'hA6, 8'hD5, 8'h80, 8'h20, 8'h00, 8'h21, 8'h00, 8'h7F, 8'h22,
    8'h00, 8'h07, 8'h8D, 8'h14, 8'hAF
  };

  logic       w_clk = 1'b0;
  logic       rst;
  host_req_t  i_host;
  logic [7:0] o_rd_data;
  logic       o_scl;
  logic       o_sda_low;
  logic       o_init_done;
  logic       w_sda;
  logic       r_ack_low;

  logic [7:0] shadow [VRAM_DEPTH];
  logic [7:0] sent_img [VRAM_DEPTH];  // shadow value as each byte went out
  logic [7:0] rx_buf [FRAME_TXN];
  logic [7:0] rx_sh;
  int         rx_len = 0;
  int         rx_bits = 0;
  int         n_txn = 0;
  int         n_checked = 0;
  bit         in_txn = 1'b0;
  bit         in_ack = 1'b0;
  bit         prev_scl = 1'b1;  // idle bus
  bit         prev_sda = 1'b1;

  assign w_sda = !(o_sda_low || r_ack_low);  // open drain with pull-up

  always #(CYC / 2) w_clk = ~w_clk;

  oled_top #(.CLK_DIV(1), .I2C_ADDR(7'h3C)) dut (
    .w_clk       (w_clk),
    .rst         (rst),
    .i_host      (i_host),
    .o_rd_data   (o_rd_data),
    .o_scl       (o_scl),
    .o_sda_low   (o_sda_low),
    .i_sda       (w_sda),
    .o_init_done (o_init_done)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic host_write(input int addr, input logic [7:0] data);
    i_host <= '{addr: VRAM_AW'(addr), wdata: data, we: 1'b1};
    shadow[addr] = data;
    @(posedge w_clk);
  endtask

  task automatic host_read(input int addr);
    i_host <= '{addr: VRAM_AW'(addr), wdata: 8'h00, we: 1'b0};
    @(posedge w_clk);  // request taken
    @(posedge w_clk);
    assert (o_rd_data === shadow[addr])
      else fail_now($sformatf("ERR o_rd_data at addr %h: got %h expected %h",
                              addr, o_rd_data, shadow[addr]));
  endtask

  // expected byte k of an init or frame transaction
  function automatic logic [7:0] ref_byte(input bit frame, input int k);
    if (k == 0) return 8'h78;  // 7'h3C with R/W# low
    if (k == 1) return frame ? 8'h40 : 8'h00;
    return frame ? sent_img[k - 2] : INIT_REF[k - 2];
  endfunction

  // i2c slave sampling the bus once per clock
  always @(posedge w_clk) begin
    if (!rst) begin
      if (prev_scl && o_scl && prev_sda && !w_sda) begin  // start
        in_txn  = 1'b1;
        in_ack  = 1'b0;
        rx_len  = 0;
        rx_bits = 0;
      end else if (in_txn && prev_scl && o_scl && !prev_sda && w_sda) begin  // stop
        in_txn = 1'b0;
        n_txn++;
      end else if (in_txn && !prev_scl && o_scl && !in_ack && rx_bits < 8) begin
        rx_sh = {rx_sh[6:0], w_sda};
        rx_bits++;
      end else if (in_txn && prev_scl && !o_scl) begin
        if (in_ack) begin
          r_ack_low <= 1'b0;
          in_ack  = 1'b0;
          rx_bits = 0;
        end else if (rx_bits == 8) begin
          assert (rx_len < FRAME_TXN)
            else fail_now("the slave received more bytes than one frame holds");
          if (rx_len >= 2) sent_img[rx_len - 2] = shadow[rx_len - 2];
          rx_buf[rx_len] = rx_sh;
          r_ack_low <= !(n_txn == NACK_TXN && rx_len == NACK_POS);
          rx_len++;
          in_ack = 1'b1;
        end
      end
      prev_scl = o_scl;
      prev_sda = w_sda;
    end
  end

  // compares each decoded transaction with the reference
  initial begin
    int exp_len;
    bit frame;
    while (n_checked < N_TXN) begin
      wait (n_txn > n_checked);
      frame   = (n_checked != 0);
      exp_len = !frame ? INIT_TXN : (n_checked == NACK_TXN) ? NACK_POS + 1 : FRAME_TXN;
      assert (rx_len == exp_len)
        else fail_now($sformatf("ERR txn_len of txn %0d: got %h expected %h",
                                n_checked, rx_len, exp_len));
      for (int k = 0; k < exp_len; k++) begin
        assert (rx_buf[k] === ref_byte(frame, k))
          else fail_now($sformatf("ERR sda_byte[%0d] of txn %0d: got %h expected %h",
                                  k, n_checked, rx_buf[k], ref_byte(frame, k)));
      end
      // low until the init stop has completed, high for every frame
      assert (o_init_done === frame)
        else fail_now($sformatf("ERR o_init_done at end of txn %0d: got %h expected %h",
                                n_checked, o_init_done, frame));
      n_checked++;
    end
    $display("Test OK");
    $finish;
  end

  // host stimulus
  initial begin
    void'($urandom(32'h4f9));
    r_ack_low = 1'b0;
    rst       = 1'b1;
    i_host    = '0;
    repeat (2) @(posedge w_clk);
    rst <= 1'b0;
    @(posedge w_clk);
    assert (o_scl === 1'b1 && o_sda_low === 1'b0 && o_init_done === 1'b0)
      else fail_now($sformatf("ERR reset: o_scl %h o_sda_low %h o_init_done %h",
                              o_scl, o_sda_low, o_init_done));
    for (int i = 0; i < VRAM_DEPTH; i++) begin
      host_write(i, 8'($urandom));
    end
    repeat (32) host_read($urandom % VRAM_DEPTH);
    wait (n_txn == 1 && rx_len > 600);  // lower half of frame 1 already sent
    @(posedge w_clk);
    repeat (64) host_write($urandom % 512, 8'($urandom));
    repeat (16) host_read($urandom % 512);
  end

  always @(posedge w_clk) begin
    assert (!dut.u_i2c.u_sva.fail_seen)
      else fail_now("a bus protocol assertion failed in the i2c master");
  end

  initial begin
    #(TIMEOUT_CYC * CYC);
    fail_now("timeout: the display transactions did not complete in time");
  end

endmodule

/* sim/oled_sva.sv */
`timescale 1ns/1ps
// i2c master protocol checks
// bound into every oled_i2c_byte instance
module oled_sva (
  input logic w_clk,
  input logic rst,
  input logic i_byte_valid,
  input logic o_need,
  input logic o_nack,
  input logic o_busy,
  input logic o_scl,
  input logic o_sda_low
);

  logic fail_seen = 1'b0;

  // sda may move with scl high only for start and stop
  sda_start: assert property (@(posedge w_clk) disable iff (rst)
    (o_scl && $past(o_scl) && $rose(o_sda_low)) |-> $rose(o_busy))
    else begin
      $error("sda fell with scl high outside a start");
      fail_seen = 1'b1;
    end

  sda_stop: assert property (@(posedge w_clk) disable iff (rst)
    (o_scl && $past(o_scl) && $fell(o_sda_low)) |-> ##1 !o_busy)
    else begin
      $error("sda rose with scl high outside a stop");
      fail_seen = 1'b1;
    end

  // need drops in the cycle after a byte is taken
  valid_need: assert property (@(posedge w_clk) disable iff (rst)
    i_byte_valid |-> o_need ##1 !o_need)
    else begin
      $error("byte offered while need was low or need stayed high after it");
      fail_seen = 1'b1;
    end

  // no further byte is requested once the slave has nacked
  nack_width: assert property (@(posedge w_clk) disable iff (rst)
    o_nack |=> !o_nack && !o_need)
    else begin
      $error("nack pulse longer than one cycle or need high after a nack");
      fail_seen = 1'b1;
    end

endmodule

bind oled_i2c_byte oled_sva u_sva (.*);

/* source/oled_top.sv */
`timescale 1ns/1ps
// oled controller top
// SSD1306 128x64 display over i2c, host-writable vram refreshed continuously
module oled_top import oled_pkg::*; #(
  parameter int         CLK_DIV  = 25,
  parameter logic [6:0] I2C_ADDR = 7'h3C
) (
  input  logic       w_clk,
  input  logic       rst,
  input  host_req_t  i_host,
  output logic [7:0] o_rd_data,
  output logic       o_scl,
  output logic       o_sda_low,  // high pulls SDA low
  input  logic       i_sda,
  output logic       o_init_done
);

  i2c_byte_t          w_byte;
  logic               w_byte_valid;
  logic               w_need;
  logic               w_nack;
  logic               w_busy;
  logic [VRAM_AW-1:0] w_scan_addr;
  logic [7:0]         w_scan_data;

  oled_vram u_vram (
    .w_clk       (w_clk),
    .i_host      (i_host),
    .o_rd_data   (o_rd_data),
    .i_scan_addr (w_scan_addr),
    .o_scan_data (w_scan_data)
  );

  oled_sequencer #(.I2C_ADDR(I2C_ADDR)) u_seq (
    .w_clk        (w_clk),
    .rst          (rst),
    .i_need       (w_need),
    .i_nack       (w_nack),
    .i_busy       (w_busy),
    .o_byte       (w_byte),
    .o_byte_valid (w_byte_valid),
    .o_scan_addr  (w_scan_addr),
    .i_scan_data  (w_scan_data),
    .o_init_done  (o_init_done)
  );

  oled_i2c_byte #(.CLK_DIV(CLK_DIV)) u_i2c (
    .w_clk        (w_clk),
    .rst          (rst),
    .i_byte       (w_byte),
    .i_byte_valid (w_byte_valid),
    .i_sda        (i_sda),
    .o_need       (w_need),
    .o_nack       (w_nack),
    .o_busy       (w_busy),
    .o_scl        (o_scl),
    .o_sda_low    (o_sda_low)
  );

endmodule

/* source/oled_sequencer.sv */
`timescale 1ns/1ps
// oled transaction sequencer
// sends the init command transaction once, then repeats frame transactions
// of all 1024 vram bytes; a nacked transaction restarts from its address byte
module oled_sequencer import oled_pkg::*; #(
  parameter logic [6:0] I2C_ADDR = 7'h3C
) (
  input  logic               w_clk,
  input  logic               rst,
  input  logic               i_need,
  input  logic               i_nack,
  input  logic               i_busy,
  output i2c_byte_t          o_byte,
  output logic               o_byte_valid,
  output logic [VRAM_AW-1:0] o_scan_addr,
  input  logic [7:0]         i_scan_data,
  output logic               o_init_done
);

  localparam int IW = VRAM_AW + 1;  // address + control + 1024 payload

  typedef enum logic {S_SEND, S_WAIT} state_t;

  state_t        r_state;
  logic          r_frame;  // 0 init, 1 frame
  logic          r_retry;  // repeat the current transaction
  logic [IW-1:0] r_idx;    // byte position in the transaction
  logic [4:0]    w_cmd_sel;
  logic [IW-1:0] w_last_idx;
  logic [7:0]    w_payload;

  assign w_cmd_sel  = 5'(r_idx - IW'(2));
  assign w_last_idx = r_frame ? IW'(VRAM_DEPTH + 1) : IW'(INIT_LEN + 1);
  assign w_payload  = r_frame ? i_scan_data : INIT_CMDS[w_cmd_sel];

  always_comb begin
    if (r_idx == '0) begin
      o_byte.data = {I2C_ADDR, 1'b0};  // write
    end else if (r_idx == IW'(1)) begin
      o_byte.data = r_frame ? CTRL_DATA : CTRL_CMD;
    end else begin
      o_byte.data = w_payload;
    end
    o_byte.last = (r_idx == w_last_idx);
  end

  // offered as soon as the master asks, it drops need the next cycle
  assign o_byte_valid = i_need && (r_state == S_SEND);

  always_ff @(posedge w_clk) begin
    if (rst) begin
      r_state     <= S_WAIT;
      r_retry     <= 1'b1;  // first pass starts the init transaction
      r_frame     <= 1'b0;
      r_idx       <= '0;
      o_scan_addr <= '0;
      o_init_done <= 1'b0;
    end else begin
      case (r_state)
        S_SEND: begin
          if (i_nack) begin
            r_state <= S_WAIT;
            r_retry <= 1'b1;
          end else if (o_byte_valid) begin
            r_idx <= r_idx + 1'b1;
            if (r_frame && r_idx >= IW'(2)) begin
              o_scan_addr <= o_scan_addr + 1'b1;  // prefetch next vram byte
            end
            if (o_byte.last) begin
              r_state <= S_WAIT;
              r_retry <= 1'b0;
            end
          end
        end
        S_WAIT: begin
          if (i_nack) begin
            r_retry <= 1'b1;  // nack on the last byte
          end else if (!i_busy) begin
            r_state     <= S_SEND;
            r_idx       <= '0;
            o_scan_addr <= '0;
            if (!r_retry) begin
              r_frame     <= 1'b1;
              o_init_done <= 1'b1;
            end
          end
        end
        default: r_state <= S_WAIT;
      endcase
    end
  end

endmodule

/* source/oled_i2c_byte.sv */
`timescale 1ns/1ps
// i2c byte master
// sends start, 8 data bits msb first, checks the ack bit and ends with stop
// after a last byte or a nack; a following byte is chained without a stop
module oled_i2c_byte import oled_pkg::*; #(
  parameter int CLK_DIV = 25
) (
  input  logic      w_clk,
  input  logic      rst,
  input  i2c_byte_t i_byte,
  input  logic      i_byte_valid,
  input  logic      i_sda,
  output logic      o_need,
  output logic      o_nack,
  output logic      o_busy,
  output logic      o_scl,
  output logic      o_sda_low
);

  localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  typedef enum logic [2:0] {S_IDLE, S_START, S_SEND, S_ACK, S_STOP} state_t;

  state_t        r_state;
  logic [DW-1:0] r_div;   // clock-enable divider
  logic [1:0]    r_q;     // quarter within the bit
  logic [2:0]    r_bit;
  logic [7:0]    r_sh;
  logic          r_last;
  logic          r_have;  // next byte already taken in ack phase
  logic          r_bad;   // ack bit was high
  logic          w_tick;

  assign w_tick = (r_div == DW'(CLK_DIV - 1));
  assign o_busy = (r_state != S_IDLE);
  assign o_need = (r_state == S_IDLE) ||
                  (r_state == S_ACK && !r_last && !r_have && !r_bad);

  always_ff @(posedge w_clk) begin
    if (rst || r_state == S_IDLE || w_tick) begin
      r_div <= '0;
    end else begin
      r_div <= r_div + 1'b1;
    end
  end

  // shift register, loaded on every accepted byte
  always_ff @(posedge w_clk) begin
    if (i_byte_valid) begin
      r_sh <= i_byte.data;
    end else if (r_state == S_SEND && w_tick && r_q == 2'd3) begin
      r_sh <= {r_sh[6:0], 1'b1};
    end
  end

  always_ff @(posedge w_clk) begin
    if (rst) begin
      r_state   <= S_IDLE;
      r_q       <= '0;
      r_bit     <= '0;
      r_last    <= 1'b0;
      r_have    <= 1'b0;
      r_bad     <= 1'b0;
      o_nack    <= 1'b0;
      o_scl     <= 1'b1;
      o_sda_low <= 1'b0;
    end else begin
      o_nack <= 1'b0;
      if (i_byte_valid) begin
        r_last <= i_byte.last;
        if (r_state == S_ACK) r_have <= 1'b1;
      end
      case (r_state)
        S_IDLE: begin
          r_q <= '0;
          if (i_byte_valid) begin
            r_state   <= S_START;
            o_sda_low <= 1'b1;  // start, SDA falls with SCL high
          end
        end
        S_START: if (w_tick) begin
          r_q <= r_q + 1'b1;
          if (r_q == 2'd1) o_scl <= 1'b0;
          if (r_q == 2'd3) begin
            r_state   <= S_SEND;
            r_bit     <= '0;
            o_sda_low <= !r_sh[7];
          end
        end
        S_SEND: if (w_tick) begin
          r_q <= r_q + 1'b1;
          if (r_q == 2'd0) o_scl <= 1'b1;
          if (r_q == 2'd2) o_scl <= 1'b0;
          if (r_q == 2'd3) begin
            if (r_bit == 3'd7) begin
              r_state   <= S_ACK;
              r_bad     <= 1'b0;
              o_sda_low <= 1'b0;  // release for the slave ack
            end else begin
              r_bit     <= r_bit + 1'b1;
              o_sda_low <= !r_sh[6];
            end
          end
        end
        S_ACK: if (w_tick) begin
          if (r_q != 2'd3) r_q <= r_q + 1'b1;
          if (r_q == 2'd0) o_scl <= 1'b1;
          if (r_q == 2'd2) begin
            o_scl <= 1'b0;
            if (i_sda) begin
              r_bad  <= 1'b1;
              o_nack <= 1'b1;
            end
          end
          if (r_q == 2'd3) begin
            if (r_bad || (r_last && !r_have)) begin
              r_state   <= S_STOP;
              r_have    <= 1'b0;
              r_q       <= '0;
              o_sda_low <= 1'b1;
            end else if (r_have) begin
              r_state   <= S_SEND;
              r_have    <= 1'b0;
              r_bit     <= '0;
              r_q       <= '0;
              o_sda_low <= !r_sh[7];
            end
            // otherwise hold SCL low until the next byte arrives
          end
        end
        S_STOP: if (w_tick) begin
          r_q <= r_q + 1'b1;
          if (r_q == 2'd0) o_scl <= 1'b1;
          if (r_q == 2'd2) o_sda_low <= 1'b0;  // stop, SDA rises with SCL high
          if (r_q == 2'd3) r_state <= S_IDLE;
        end
        default: r_state <= S_IDLE;
      endcase
    end
  end

endmodule

/* source/oled_vram.sv */
`timescale 1ns/1ps
// oled video memory
// 1024 x 8 frame buffer with a host read/write port and a read-only scan
// port, both reads registered
module oled_vram import oled_pkg::*; (
  input  logic               w_clk,
  input  host_req_t          i_host,
  output logic [7:0]         o_rd_data,
  input  logic [VRAM_AW-1:0] i_scan_addr,
  output logic [7:0]         o_scan_data
);

  logic [7:0] mem [VRAM_DEPTH];

  initial begin
    for (int i = 0; i < VRAM_DEPTH; i++) begin
      mem[i] = '0;  // blank screen at power-up
    end
  end

  // host port
  always_ff @(posedge w_clk) begin
    if (i_host.we) begin
      mem[i_host.addr] <= i_host.wdata;
    end
    o_rd_data <= mem[i_host.addr];  // old data on a same-cycle write
  end

  // scan port, feeds the frame refresh
  always_ff @(posedge w_clk) begin
    o_scan_data <= mem[i_scan_addr];
  end

endmodule

/* source/oled_pkg.sv */
// oled package
// shared sizes, host and byte structs, and the SSD1306 power-up command table
// for a 128x64 panel in horizontal addressing mode
package oled_pkg;

  localparam int VRAM_DEPTH = 1024;  // 128 columns x 8 pages
  localparam int VRAM_AW    = 10;
  localparam int INIT_LEN   = 25;

  localparam logic [7:0] CTRL_CMD  = 8'h00;  // Co=0, D/C#=0
  localparam logic [7:0] CTRL_DATA = 8'h40;  // Co=0, D/C#=1

  localparam logic [7:0] INIT_CMDS [INIT_LEN] = '{
    8'hAE,                // display off
    8'hA8, 8'h3F,         // mux ratio 64
    8'h40,                // start line 0
    8'hA0,                // segment remap off
    8'hC0,                // com scan normal
    8'hDA, 8'h12,         // com pin config
    8'h81, 8'h7F,         // contrast
    8'hA4,                // follow ram content
    8'hA6,                // normal, not inverted
    8'hD5, 8'h80,         // osc freq and clock ratio
    8'h20, 8'h00,         // horizontal addressing
    8'h21, 8'h00, 8'h7F,  // columns 0..127
    8'h22, 8'h00, 8'h07,  // pages 0..7
    8'h8D, 8'h14,         // charge pump on
    8'hAF                 // display on
  };

  // host access to the video memory
  typedef struct packed {
    logic [VRAM_AW-1:0] addr;
    logic [7:0]         wdata;
    logic               we;
  } host_req_t;

  // one byte handed to the i2c master
  typedef struct packed {
    logic [7:0] data;
    logic       last;  // stop after this byte
  } i2c_byte_t;

endpackage
